/* logic/bp_config.svh */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// index bits per table for 256 counters each
`define BP_INDEX_BITS 8

// global history width
// must not exceed BP_INDEX_BITS
`define BP_HISTORY_BITS 8

// lowest pc bit used for indexing
// instructions are word aligned
`define BP_PC_LSB 2

`endif

/* logic/bp_pkg.sv */
`include "bp_config.svh"

package bp_pkg;

	// upper bit is the predicted direction
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken = 2'b01,
		weak_taken = 2'b10,
		strong_taken = 2'b11
	} counter_e;

	localparam counter_e counter_reset = weak_not_taken;

	typedef enum logic [1:0] {
		table_local = 2'd0,
		table_gshare = 2'd1,
		table_chooser = 2'd2
	} table_e;

	typedef enum logic {
		source_local = 1'b0,
		source_gshare = 1'b1
	} source_e;

	typedef logic [`BP_INDEX_BITS-1:0] index_t;
	typedef logic [`BP_HISTORY_BITS-1:0] history_t;

endpackage : bp_pkg

/* logic/predictor_index.sv */
`include "bp_config.svh"

module predictor_index (
	input logic clk,
	input logic reset,
	input logic lookup,
	input logic [31:0] lookup_pc,
	input logic resolve,
	input logic [31:0] resolve_pc,
	input logic resolve_taken,
	input bp_pkg::history_t resolve_history,
	output bp_pkg::index_t read_index [bp_pkg::table_local:bp_pkg::table_chooser],
	output bp_pkg::index_t update_index [bp_pkg::table_local:bp_pkg::table_chooser],
	output bp_pkg::history_t predict_history
);

	bp_pkg::history_t global_history;
	bp_pkg::index_t lookup_bits;
	bp_pkg::index_t resolve_bits;
	bp_pkg::index_t lookup_hash;
	bp_pkg::index_t resolve_hash;

	assign lookup_bits = lookup_pc[`BP_PC_LSB +: `BP_INDEX_BITS];
	assign resolve_bits = resolve_pc[`BP_PC_LSB +: `BP_INDEX_BITS];

	// history is zero extended into the low index bits
	assign lookup_hash = lookup_bits ^ bp_pkg::index_t'(global_history);
	// resolve uses the history seen at that branch's lookup
	assign resolve_hash = resolve_bits ^ bp_pkg::index_t'(resolve_history);

	// lookup side
	assign read_index[bp_pkg::table_local] = lookup_bits;
	assign read_index[bp_pkg::table_gshare] = lookup_hash;
	assign read_index[bp_pkg::table_chooser] = lookup_bits;

	// resolve side
	assign update_index[bp_pkg::table_local] = resolve_bits;
	assign update_index[bp_pkg::table_gshare] = resolve_hash;
	assign update_index[bp_pkg::table_chooser] = resolve_bits;

	always_ff @(posedge clk) begin
		if (reset) begin
			global_history <= '0;
			predict_history <= '0;
		end else begin
			// shift in the outcome as the oldest bit falls off
			if (resolve) begin
				global_history <= bp_pkg::history_t'({global_history, resolve_taken});
			end
			// history from before any same-cycle resolve
			if (lookup) begin
				predict_history <= global_history;
			end
		end
	end

endmodule : predictor_index

/* logic/counter_table.sv */
`include "bp_config.svh"

module counter_table (
	input logic clk,
	input logic reset,
	input logic lookup,
	input bp_pkg::index_t read_index,
	input logic update,
	input bp_pkg::index_t update_index,
	input logic update_up,
	output bp_pkg::counter_e read_counter,
	output bp_pkg::counter_e update_counter
);

	localparam int depth = 2 ** `BP_INDEX_BITS;

	bp_pkg::counter_e counters [depth];
	bp_pkg::counter_e stepped;

	// current value at the resolve index
	assign update_counter = counters[update_index];

	// saturating step toward the outcome
	always_comb begin
		stepped = update_counter;
		unique case (update_counter)
			bp_pkg::strong_not_taken: begin
				stepped = update_up ? bp_pkg::weak_not_taken : bp_pkg::strong_not_taken;
			end
			bp_pkg::weak_not_taken: begin
				stepped = update_up ? bp_pkg::weak_taken : bp_pkg::strong_not_taken;
			end
			bp_pkg::weak_taken: begin
				stepped = update_up ? bp_pkg::strong_taken : bp_pkg::weak_not_taken;
			end
			bp_pkg::strong_taken: begin
				stepped = update_up ? bp_pkg::strong_taken : bp_pkg::weak_taken;
			end
			default: begin
				stepped = bp_pkg::counter_reset;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				counters[i] <= bp_pkg::counter_reset;
			end
			read_counter <= bp_pkg::counter_reset;
		end else begin
			if (update) begin
				counters[update_index] <= stepped;
			end
			// old contents win over a same-cycle write
			if (lookup) begin
				read_counter <= counters[read_index];
			end
		end
	end

endmodule : counter_table

/* logic/tournament_choice.sv */
`include "bp_config.svh"

module tournament_choice (
	input logic clk,
	input logic reset,
	input logic lookup,
	input bp_pkg::counter_e read_counter [bp_pkg::table_local:bp_pkg::table_chooser],
	input bp_pkg::counter_e update_counter [bp_pkg::table_local:bp_pkg::table_chooser],
	input logic resolve_taken,
	output logic predict_valid,
	output logic predict_taken,
	output bp_pkg::source_e predict_source,
	output logic chooser_update,
	output logic chooser_up
);

	bp_pkg::counter_e chooser_read;
	bp_pkg::counter_e selected;
	logic local_right;
	logic gshare_right;

	always_ff @(posedge clk) begin
		if (reset) begin
			predict_valid <= 1'b0;
		end else begin
			predict_valid <= lookup;
		end
	end

	// read counters hold until the next lookup, so these do too
	assign chooser_read = read_counter[bp_pkg::table_chooser];
	assign predict_source = chooser_read[1] ? bp_pkg::source_gshare : bp_pkg::source_local;

	always_comb begin
		unique case (predict_source)
			bp_pkg::source_gshare: selected = read_counter[bp_pkg::table_gshare];
			default: selected = read_counter[bp_pkg::table_local];
		endcase
	end

	assign predict_taken = selected[1];

	// judged on the counters before this resolve's update
	assign local_right = (update_counter[bp_pkg::table_local][1] == resolve_taken);
	assign gshare_right = (update_counter[bp_pkg::table_gshare][1] == resolve_taken);

	// only train when the two tables disagree in correctness
	assign chooser_update = local_right ^ gshare_right;
	// up means toward gshare
	assign chooser_up = gshare_right;

endmodule : tournament_choice

/* logic/tournament_predictor.sv */
`include "bp_config.svh"

module tournament_predictor (
	input logic clk,
	input logic reset,
	input logic lookup,
	input logic [31:0] lookup_pc,
	input logic resolve,
	input logic [31:0] resolve_pc,
	input logic resolve_taken,
	input bp_pkg::history_t resolve_history,
	output logic predict_valid,
	output logic predict_taken,
	output bp_pkg::source_e predict_source,
	output bp_pkg::history_t predict_history
);

	bp_pkg::index_t read_index [bp_pkg::table_local:bp_pkg::table_chooser];
	bp_pkg::index_t update_index [bp_pkg::table_local:bp_pkg::table_chooser];
	bp_pkg::counter_e read_counter [bp_pkg::table_local:bp_pkg::table_chooser];
	bp_pkg::counter_e update_counter [bp_pkg::table_local:bp_pkg::table_chooser];
	logic table_update [bp_pkg::table_local:bp_pkg::table_chooser];
	logic table_up [bp_pkg::table_local:bp_pkg::table_chooser];
	logic chooser_update;
	logic chooser_up;

	predictor_index index_gen (
		.clk(clk),
		.reset(reset),
		.lookup(lookup),
		.lookup_pc(lookup_pc),
		.resolve(resolve),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.resolve_history(resolve_history),
		.read_index(read_index),
		.update_index(update_index),
		.predict_history(predict_history)
	);

	for (genvar t = bp_pkg::table_local; t <= bp_pkg::table_chooser; t++) begin : g_table
		if (t == bp_pkg::table_chooser) begin : g_chooser
			assign table_update[t] = chooser_update & resolve;
			assign table_up[t] = chooser_up;
		end else begin : g_direction
			// direction tables train on every resolve
			assign table_update[t] = resolve;
			assign table_up[t] = resolve_taken;
		end

		counter_table counters (
			.clk(clk),
			.reset(reset),
			.lookup(lookup),
			.read_index(read_index[t]),
			.update(table_update[t]),
			.update_index(update_index[t]),
			.update_up(table_up[t]),
			.read_counter(read_counter[t]),
			.update_counter(update_counter[t])
		);
	end

	tournament_choice choice (
		.clk(clk),
		.reset(reset),
		.lookup(lookup),
		.read_counter(read_counter),
		.update_counter(update_counter),
		.resolve_taken(resolve_taken),
		.predict_valid(predict_valid),
		.predict_taken(predict_taken),
		.predict_source(predict_source),
		.chooser_update(chooser_update),
		.chooser_up(chooser_up)
	);

endmodule : tournament_predictor

/* testbench/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// held for 4 rising edges and released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule : tb_clock

/* testbench/tournament_predictor_tb.sv */
`include "bp_config.svh"

module tournament_predictor_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int table_depth = 2 ** `BP_INDEX_BITS;
	localparam int random_cycles = 2000;
	localparam int directed_branches = 80;
	localparam int stim_cycles = 8 + directed_branches * 4 + random_cycles + 16;
	localparam int run_limit_ns = (stim_cycles + 100) * 4;

	logic clk;
	logic reset;
	logic lookup;
	logic [31:0] lookup_pc;
	logic resolve;
	logic [31:0] resolve_pc;
	logic resolve_taken;
	bp_pkg::history_t resolve_history;
	logic predict_valid;
	logic predict_taken;
	bp_pkg::source_e predict_source;
	bp_pkg::history_t predict_history;

	// model tables and history
	logic [1:0] local_model [table_depth];
	logic [1:0] gshare_model [table_depth];
	logic [1:0] chooser_model [table_depth];
	bp_pkg::history_t model_history;

	// expected results in lookup order
	logic want_taken [$];
	bp_pkg::source_e want_source [$];
	bp_pkg::history_t want_history [$];

	// looked up but not yet resolved
	logic [31:0] open_pc [$];
	bp_pkg::history_t open_history [$];

	logic lookup_seen;
	logic [31:0] pc_pool [4] = '{32'h0000_1104, 32'h0000_1208, 32'h0000_130c, 32'h0000_1190};

	tb_clock clock_gen (
		.clk(clk),
		.reset(reset)
	);

	tournament_predictor DUT (
		.clk(clk),
		.reset(reset),
		.lookup(lookup),
		.lookup_pc(lookup_pc),
		.resolve(resolve),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.resolve_history(resolve_history),
		.predict_valid(predict_valid),
		.predict_taken(predict_taken),
		.predict_source(predict_source),
		.predict_history(predict_history)
	);

	task automatic report_failure();
		$display("ERRORS FOUND");
		$fatal(1, "stopping at the first failure");
	endtask

	function automatic logic [1:0] saturate_step(input logic [1:0] count, input logic up);
		if (up && count != 2'b11) begin
			return count + 2'b01;
		end
		if (!up && count != 2'b00) begin
			return count - 2'b01;
		end
		return count;
	endfunction

	function automatic bp_pkg::index_t pc_index(input logic [31:0] pc);
		return pc[`BP_PC_LSB +: `BP_INDEX_BITS];
	endfunction

	// lookup sees the model before any same-cycle resolve
	function automatic void predict_ref(
		input logic [31:0] pc,
		output logic taken,
		output bp_pkg::source_e source,
		output bp_pkg::history_t history
	);
		bp_pkg::index_t idx;
		bp_pkg::index_t hashed;
		idx = pc_index(pc);
		hashed = idx ^ bp_pkg::index_t'(model_history);
		source = chooser_model[idx][1] ? bp_pkg::source_gshare : bp_pkg::source_local;
		taken = chooser_model[idx][1] ? gshare_model[hashed][1] : local_model[idx][1];
		history = model_history;
	endfunction

	function automatic void resolve_ref(
		input logic [31:0] pc,
		input logic taken,
		input bp_pkg::history_t history
	);
		bp_pkg::index_t idx;
		bp_pkg::index_t hashed;
		logic local_ok;
		logic gshare_ok;
		idx = pc_index(pc);
		hashed = idx ^ bp_pkg::index_t'(history);
		local_ok = (local_model[idx][1] == taken);
		gshare_ok = (gshare_model[hashed][1] == taken);
		// chooser trains only when exactly one table was right
		if (local_ok != gshare_ok) begin
			chooser_model[idx] = saturate_step(chooser_model[idx], gshare_ok);
		end
		local_model[idx] = saturate_step(local_model[idx], taken);
		gshare_model[hashed] = saturate_step(gshare_model[hashed], taken);
		model_history = bp_pkg::history_t'({model_history, taken});
	endfunction

	task automatic drive_cycle(
		input logic do_lookup,
		input logic [31:0] l_pc,
		input logic do_resolve,
		input logic [31:0] r_pc,
		input logic r_taken,
		input bp_pkg::history_t r_history
	);
		logic exp_taken;
		bp_pkg::source_e exp_source;
		bp_pkg::history_t exp_history;
		@(negedge clk);
		lookup = do_lookup;
		lookup_pc = l_pc;
		resolve = do_resolve;
		resolve_pc = r_pc;
		resolve_taken = r_taken;
		resolve_history = r_history;
		if (do_lookup) begin
			predict_ref(l_pc, exp_taken, exp_source, exp_history);
			want_taken.push_back(exp_taken);
			want_source.push_back(exp_source);
			want_history.push_back(exp_history);
		end
		if (do_resolve) begin
			resolve_ref(r_pc, r_taken, r_history);
		end
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
	endtask

	// lookup, wait for the answer, then resolve with the returned history
	task automatic run_branch(
		input logic [31:0] pc,
		input logic taken,
		output logic predicted,
		output bp_pkg::source_e source
	);
		bp_pkg::history_t seen;
		int waited;
		drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0);
		waited = 0;
		do begin
			idle_cycle();
			waited++;
		end while (predict_valid !== 1'b1 && waited < 8);
		assert (predict_valid === 1'b1) else begin
			$display("no prediction came back within 8 cycles of a lookup");
			report_failure();
		end
		predicted = predict_taken;
		source = predict_source;
		seen = predict_history;
		drive_cycle(1'b0, '0, 1'b1, pc, taken, seen);
	endtask

	always @(posedge clk) begin : compare_outputs
		logic exp_taken;
		bp_pkg::source_e exp_source;
		bp_pkg::history_t exp_history;
		if (reset) begin
			lookup_seen = 1'b0;
		end else begin
			assert (predict_valid === lookup_seen) else begin
				$display("[ERROR] %0t predict_valid expected %b actual %b",
					$time, lookup_seen, predict_valid);
				report_failure();
			end
			if (predict_valid === 1'b1) begin
				assert (want_taken.size() > 0) else begin
					$display("a prediction arrived with no lookup outstanding");
					report_failure();
				end
				exp_taken = want_taken.pop_front();
				exp_source = want_source.pop_front();
				exp_history = want_history.pop_front();
				assert (predict_taken === exp_taken) else begin
					$display("[ERROR] %0t predict_taken expected %b actual %b",
						$time, exp_taken, predict_taken);
					report_failure();
				end
				assert (predict_source === exp_source) else begin
					$display("[ERROR] %0t predict_source expected %b actual %b",
						$time, exp_source, predict_source);
					report_failure();
				end
				assert (predict_history === exp_history) else begin
					$display("[ERROR] %0t predict_history expected %h actual %h",
						$time, exp_history, predict_history);
					report_failure();
				end
			end
			lookup_seen = lookup;
		end
	end

	initial begin : watchdog
		#(run_limit_ns);
		$display("timeout, the stimulus did not finish within %0d ns", run_limit_ns);
		report_failure();
	end

	initial begin : stimulus
		logic predicted;
		bp_pkg::source_e source;
		logic do_lookup;
		logic do_resolve;
		logic [31:0] l_pc;
		logic [31:0] r_pc;
		logic r_taken;
		bp_pkg::history_t r_history;
		void'($urandom(32'hcda5_f839));
		lookup = 1'b0;
		lookup_pc = '0;
		resolve = 1'b0;
		resolve_pc = '0;
		resolve_taken = 1'b0;
		resolve_history = '0;
		lookup_seen = 1'b0;
		for (int i = 0; i < table_depth; i++) begin
			local_model[i] = 2'b01;
			gshare_model[i] = 2'b01;
			chooser_model[i] = 2'b01;
		end
		model_history = '0;
		@(negedge reset);

		// first lookup after a quiet reset is local not-taken
		repeat (4) idle_cycle();
		run_branch(32'h0000_0010, 1'b1, predicted, source);
		assert (predicted === 1'b0) else begin
			$display("[ERROR] %0t predict_taken expected 0 actual %b", $time, predicted);
			report_failure();
		end
		assert (source === bp_pkg::source_local) else begin
			$display("[ERROR] %0t predict_source expected %b actual %b",
				$time, bp_pkg::source_local, source);
			report_failure();
		end

		// two taken outcomes train the local counter
		run_branch(32'h0000_0020, 1'b1, predicted, source);
		run_branch(32'h0000_0020, 1'b1, predicted, source);
		run_branch(32'h0000_0020, 1'b1, predicted, source);
		assert (predicted === 1'b1) else begin
			$display("[ERROR] %0t predict_taken expected 1 actual %b", $time, predicted);
			report_failure();
		end

		// saturated counter survives one not-taken
		repeat (8) run_branch(32'h0000_0030, 1'b1, predicted, source);
		run_branch(32'h0000_0030, 1'b0, predicted, source);
		run_branch(32'h0000_0030, 1'b1, predicted, source);
		assert (predicted === 1'b1) else begin
			$display("[ERROR] %0t predict_taken expected 1 actual %b", $time, predicted);
			report_failure();
		end

		// alternating pattern lets gshare take over
		for (int k = 0; k < 48; k++) begin
			run_branch(32'h0000_0040, k[0], predicted, source);
		end
		for (int k = 48; k < 64; k++) begin
			run_branch(32'h0000_0040, k[0], predicted, source);
			assert (source === bp_pkg::source_gshare) else begin
				$display("[ERROR] %0t predict_source expected %b actual %b",
					$time, bp_pkg::source_gshare, source);
				report_failure();
			end
			assert (predicted === k[0]) else begin
				$display("[ERROR] %0t predict_taken expected %b actual %b",
					$time, k[0], predicted);
				report_failure();
			end
		end

		// mixed traffic where lookup and resolve often share a cycle
		repeat (random_cycles) begin
			do_lookup = ($urandom_range(0, 1) == 1);
			do_resolve = (open_pc.size() > 0) && ($urandom_range(0, 1) == 1);
			l_pc = pc_pool[$urandom_range(0, 3)];
			r_pc = '0;
			r_history = '0;
			r_taken = ($urandom_range(0, 1) == 1);
			if (do_resolve) begin
				r_pc = open_pc.pop_front();
				r_history = open_history.pop_front();
			end
			if (do_lookup) begin
				open_pc.push_back(l_pc);
				open_history.push_back(model_history);
			end
			drive_cycle(do_lookup, l_pc, do_resolve, r_pc, r_taken, r_history);
		end

		repeat (8) idle_cycle();
		if (want_taken.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d lookups never produced a prediction", want_taken.size());
			report_failure();
		end
	end

endmodule : tournament_predictor_tb

/* compile.f */
+incdir+logic
logic/bp_pkg.sv
logic/predictor_index.sv
logic/counter_table.sv
logic/tournament_choice.sv
logic/tournament_predictor.sv
testbench/tb_clock.sv
testbench/tournament_predictor_tb.sv

/* Makefile */
# Verilator build and run for the tournament predictor testbench

VERILATOR ?= verilator
TOP ?= tournament_predictor_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= compile.f
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: simulate clean

# the exit status comes from the search for the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -x "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
